// ==== compile.f ====
+incdir+include
hw/mcpu_bus_pkg.sv
hw/mcpu_isa_pkg.sv
hw/mcpu_segment_regs.sv
hw/mcpu_core.sv
hw/mcpu_wb_master.sv
hw/mcpu_top.sv
tb/tb_clk_gen.sv
tb/tb_mcpu_top.sv

// ==== Bender.yml ====
package:
  name: mcpu

sources:
  - include_dirs:
      - include
    files:
      - hw/mcpu_bus_pkg.sv
      - hw/mcpu_isa_pkg.sv
      - hw/mcpu_segment_regs.sv
      - hw/mcpu_core.sv
      - hw/mcpu_wb_master.sv
      - hw/mcpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_mcpu_top.sv

// ==== tb/mcpu_input.dat ====
# M byte address, word | I cycle, vector | O port, data | E byte address, word
# all fields hex
M 100 1000
M 102 1234
M 104 6010
M 106 1000
M 108 0040
M 10a 7200
M 10c 1000
M 10e beef
M 110 3205
M 112 1000
M 114 0077
M 116 3a08
M 118 2205
M 11a 6012
M 11c 2a08
M 11e 420a
M 120 6014
M 122 9000
M 124 220c
M 126 8800
M 128 0124
M 12a 1000
M 12c 5a5a
M 12e 6016
M 130 c000
M 180 1000
M 182 00c3
M 184 320c
M 186 6018
M 188 b000
M 404 1100
M 406 2233
M 408 4455
M 40a fff0
M 40c 0000
I 2bc 60
O 10 1234
O 12 beef
O 14 0067
O 18 00c3
O 16 5a5a
E 404 ef00
E 406 22be
E 408 4477
E 40a fff0
E 40c 00c3

// ==== tb/tb_mcpu_top.sv ====
`timescale 1ns/100ps

`include "mcpu_config.svh"

module tb_mcpu_top;

  import mcpu_bus_pkg::*;

  localparam int halt_idle_cycles = 64;  // no cyc this long means halted

  logic        clk;
  logic        arst_n;
  logic [15:0] wb_dat = 16'h0000;
  logic        wb_ack = 1'b0;
  logic        intr   = 1'b0;
  wb_out_t     wb;
  logic        inta;
  logic [19:0] pc;

  logic [15:0] mem [4096];        // 8 KiB of word indexed storage
  logic [ 1:0] wait_cnt = 2'd0;
  logic        active   = 1'b0;   // slave has picked up the strobe
  integer      seed     = 32'h35aa264e;
  int          cycle_cnt   = 0;
  int          idle_cnt    = 0;
  int          cycle_limit = 0;
  int          irq_cycle   = -1;
  int          irq_cnt     = 0;   // I records
  logic [ 7:0] irq_vec     = 8'h00;
  int          inta_cnt    = 0;
  logic        after_inta  = 1'b0;
  logic [19:0] o_port [$];        // expected io writes in order
  logic [15:0] o_dat  [$];
  int          o_idx = 0;
  logic [19:0] e_adr  [$];        // expected final memory words
  logic [15:0] e_dat  [$];

  tb_clk_gen clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mcpu_top mcpu_top_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_dat_i (wb_dat),
    .wb_ack_i (wb_ack),
    .intr_i   (intr),
    .wb_o     (wb),
    .inta_o   (inta),
    .pc_o     (pc)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) abort_run($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
  endtask

  function automatic logic expected_write(input logic [19:0] badr);
    logic hit;
    hit = 1'b0;
    foreach (e_adr[i]) if (e_adr[i] == badr) hit = 1'b1;
    return hit;
  endfunction

  // tag letter plus two hex fields per record and # for comment lines
  task automatic load_input();
    int          fd;
    int          ch;
    int          code;
    int          m_cnt;
    int          i;
    logic [ 7:0] tag;
    logic [31:0] a;
    logic [31:0] b;
    m_cnt = 0;
    for (i = 0; i < 4096; i++) mem[i] = {4'h0, i[11:0]} ^ 16'h9c00;  // per address fill
    fd = $fopen("tb/mcpu_input.dat", "r");
    if (fd == 0) abort_run("cannot open tb/mcpu_input.dat");
    while ($fscanf(fd, " %c", tag) == 1) begin
      if (tag == "#") begin
        ch = 0;
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);  // skip rest of line
      end else begin
        code = $fscanf(fd, "%h %h", a, b);
        if (code != 2) abort_run("malformed record in tb/mcpu_input.dat");
        case (tag)
          "M": begin
            mem[a[12:1]] = b[15:0];
            m_cnt++;
          end
          "I": begin
            irq_cycle = a;
            irq_vec   = b[7:0];
            irq_cnt++;
          end
          "O": begin
            o_port.push_back(a[19:0]);
            o_dat.push_back(b[15:0]);
          end
          "E": begin
            e_adr.push_back(a[19:0]);
            e_dat.push_back(b[15:0]);
          end
          default: abort_run("unknown record type in tb/mcpu_input.dat");
        endcase
      end
    end
    $fclose(fd);
    cycle_limit = 40 * m_cnt + 200;
  endtask

  // one acknowledged wishbone access with tga high for memory
  task automatic serve_access();
    logic [19:0] badr;
    logic [19:0] handler_adr;
    badr = {wb.adr, 1'b0};
    if (wb.tga) begin
      if (wb.adr[19:13] != 0) abort_run($sformatf("memory access at %05h outside the model", badr));
      if (wb.we) begin
        if (!expected_write(badr))
          abort_run($sformatf("memory write at %05h outside the expected data words", badr));
        if (wb.sel[0]) mem[wb.adr[12:1]][7:0]  <= wb.dat[7:0];
        if (wb.sel[1]) mem[wb.adr[12:1]][15:8] <= wb.dat[15:8];
      end else begin
        if (after_inta) begin  // first fetch of the handler
          handler_adr = {`MCPU_RESET_CS, 4'h0} + (20'(irq_vec) << `MCPU_VEC_SHIFT);
          check_equal("handler fetch address", handler_adr, badr);
          check_equal("pc at handler entry", handler_adr, pc);
          after_inta <= 1'b0;
        end
        wb_dat <= mem[wb.adr[12:1]];
      end
    end else if (wb.we) begin
      if (o_idx >= o_port.size()) abort_run("more io writes than expected");
      check_equal($sformatf("io port of write %0d", o_idx), o_port[o_idx], badr);
      check_equal($sformatf("io data of write %0d", o_idx), o_dat[o_idx], wb.dat);
      o_idx <= o_idx + 1;
    end else begin
      if (!inta) abort_run("io read seen outside an interrupt acknowledge");
      inta_cnt   <= inta_cnt + 1;
      after_inta <= 1'b1;
      wb_dat     <= {8'h00, irq_vec};  // vector on the low lane
    end
  endtask

  // slave with random wait states before each ack
  always @(posedge clk) begin
    wb_ack <= 1'b0;
    if (arst_n && wb.cyc && wb.stb && !wb_ack) begin
      if (!active) begin
        active   <= 1'b1;
        wait_cnt <= 2'($random(seed));
      end else if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        active <= 1'b0;
        wb_ack <= 1'b1;
        serve_access();
      end
    end
  end

  // interrupt source, halt detect and timeout
  always @(posedge clk) begin
    if (arst_n) begin
      cycle_cnt <= cycle_cnt + 1;
      idle_cnt  <= wb.cyc ? 0 : idle_cnt + 1;
      if (cycle_cnt == irq_cycle) intr <= 1'b1;
      if (inta) intr <= 1'b0;  // request taken
      if (cycle_cnt >= cycle_limit)
        abort_run($sformatf("timeout, no halt within %0d cycles", cycle_limit));
    end
  end

  initial begin
    load_input();
    wait (arst_n);
    while (idle_cnt < halt_idle_cycles) @(posedge clk);
    check_equal("io write count", o_port.size(), o_idx);
    check_equal("interrupt acknowledge count", irq_cnt, inta_cnt);
    foreach (e_adr[i])
      check_equal($sformatf("memory word %05h", e_adr[i]), e_dat[i], mem[e_adr[i][12:1]]);
    $display("test passed");
    $finish;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  // reset held over the first 4 rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// ==== hw/mcpu_top.sv ====
`timescale 1ns/100ps

module mcpu_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [15:0]           wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  intr_i,
  output mcpu_bus_pkg::wb_out_t wb_o,
  output logic                  inta_o,
  output logic [19:0]           pc_o     // debug fetch address
);

  import mcpu_bus_pkg::*;
  import mcpu_isa_pkg::*;

  cpu_req_t    core_req;   // from core, no memory address yet
  cpu_req_t    bus_req;    // with the physical address merged in
  logic        mem_op;
  logic        block;
  logic [15:0] cpu_dat;    // read data from master
  logic [15:0] iid_dat;    // vector or read data
  seg_sel_e    seg_sel;
  logic [15:0] offset;
  logic        seg_we;
  logic [15:0] seg_dat;
  logic [19:0] seg_adr;

  mcpu_core core_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .intr_i    (intr_i),
    .inta_o    (inta_o),
    .req_o     (core_req),
    .mem_op_o  (mem_op),
    .block_i   (block),
    .dat_i     (cpu_dat),
    .iid_dat_i (iid_dat),
    .seg_sel_o (seg_sel),
    .offset_o  (offset),
    .seg_we_o  (seg_we),
    .seg_dat_o (seg_dat),
    .pc_o      (pc_o)
  );

  mcpu_segment_regs segment_regs_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .we_i     (seg_we),
    .sel_i    (seg_sel),
    .dat_i    (seg_dat),
    .offset_i (offset),
    .adr_o    (seg_adr)
  );

  // memory goes through the segment adder, io keeps the port address
  always_comb begin
    bus_req = core_req;
    if (core_req.m_io) bus_req.adr = seg_adr;
  end

  mcpu_wb_master wb_master_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (bus_req),
    .mem_op_i (mem_op),
    .block_o  (block),
    .dat_o    (cpu_dat),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_o     (wb_o)
  );

  // raw bus word during acknowledge so the core sees the vector byte
  assign iid_dat = inta_o ? wb_dat_i : cpu_dat;

endmodule

// ==== hw/mcpu_wb_master.sv ====
`timescale 1ns/100ps

module mcpu_wb_master (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  mcpu_bus_pkg::cpu_req_t req_i,
  input  logic                   mem_op_i,
  output logic                   block_o,
  output logic [15:0]            dat_o,
  input  logic [15:0]            wb_dat_i,
  input  logic                   wb_ack_i,
  output mcpu_bus_pkg::wb_out_t  wb_o
);

  typedef enum logic [1:0] {IDLE, FIRST, GAP, SECOND} state_e;

  state_e      state_q;
  logic        split;      // word at odd address
  logic        final_ack;
  logic [ 1:0] sel_first;
  logic [15:0] dat_first;
  logic [ 7:0] lo_q;       // first byte of a split read

  assign split = !req_i.byte_op && req_i.adr[0];

  // odd address always hits the high lane, split or not
  always_comb begin
    if (req_i.adr[0]) sel_first = 2'b10;
    else if (req_i.byte_op) sel_first = 2'b01;
    else sel_first = 2'b11;
  end

  // single bytes go out on both lanes, sel picks the right one
  assign dat_first = (req_i.byte_op || req_i.adr[0]) ? {2{req_i.dat[7:0]}} : req_i.dat;

  // last ack of the access releases the core
  assign final_ack = wb_ack_i && ((state_q == FIRST && !split) || state_q == SECOND);
  assign block_o   = mem_op_i && !final_ack;

  // read data, valid when block_o is low
  always_comb begin
    if (state_q == SECOND) dat_o = {wb_dat_i[7:0], lo_q};  // high byte from even addr
    else if (req_i.byte_op) dat_o = {8'h00, req_i.adr[0] ? wb_dat_i[15:8] : wb_dat_i[7:0]};
    else dat_o = wb_dat_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      wb_o    <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (mem_op_i) begin  // cycle starts one clock after the request
            wb_o.adr <= req_i.adr[19:1];
            wb_o.dat <= dat_first;
            wb_o.sel <= sel_first;
            wb_o.we  <= req_i.we;
            wb_o.tga <= req_i.m_io;
            wb_o.stb <= 1'b1;
            wb_o.cyc <= 1'b1;
            state_q  <= FIRST;
          end
        end
        FIRST: begin
          if (wb_ack_i) begin
            wb_o.stb <= 1'b0;
            if (split) begin
              state_q <= GAP;  // keep cyc, drop stb for one clock
            end else begin
              wb_o.cyc <= 1'b0;
              wb_o.we  <= 1'b0;
              state_q  <= IDLE;
            end
          end
        end
        GAP: begin
          wb_o.adr <= req_i.adr[19:1] + 19'd1;  // next word, even byte
          wb_o.dat <= {2{req_i.dat[15:8]}};
          wb_o.sel <= 2'b01;
          wb_o.stb <= 1'b1;
          state_q  <= SECOND;
        end
        default: begin
          if (wb_ack_i) begin
            wb_o.stb <= 1'b0;
            wb_o.cyc <= 1'b0;
            wb_o.we  <= 1'b0;
            state_q  <= IDLE;
          end
        end
      endcase
    end
  end

  // low half of a split word, odd byte arrives on the high lane
  always_ff @(posedge clk_i) begin
    if (state_q == FIRST && wb_ack_i && split) lo_q <= wb_dat_i[15:8];
  end

endmodule

// ==== hw/mcpu_core.sv ====
`timescale 1ns/100ps

`include "mcpu_config.svh"

module mcpu_core (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   intr_i,
  output logic                   inta_o,
  output mcpu_bus_pkg::cpu_req_t req_o,     // adr only filled in for io
  output logic                   mem_op_o,
  input  logic                   block_i,
  input  logic [15:0]            dat_i,
  input  logic [15:0]            iid_dat_i, // vector on wb_dat_i during inta
  output mcpu_isa_pkg::seg_sel_e seg_sel_o,
  output logic [15:0]            offset_o,
  output logic                   seg_we_o,
  output logic [15:0]            seg_dat_o,
  output logic [19:0]            pc_o
);

  import mcpu_isa_pkg::*;

  typedef enum logic [2:0] {S_FETCH, S_IMM, S_EXEC, S_INTA, S_HALT} state_e;

  state_e      state_q;
  state_e      bound_state;  // where the next instruction starts
  logic [15:0] ip_q;
  logic [15:0] cs_q;         // shadow of CS for the debug pc
  logic        ie_q;
  logic [15:0] saved_ip_q;
  logic [15:0] acc_q;
  logic        zf_q;
  instr_u      ir_q;
  instr_u      fetched;      // word coming back on a fetch
  opcode_e     op;
  logic        data_op;      // exec state needs a bus cycle
  logic        io_op;
  logic        load_acc;
  logic        jmp_taken;
  logic [15:0] result;

  assign fetched     = dat_i;
  assign op          = ir_q.mem.op;
  assign io_op       = op inside {IN, OUT};
  assign data_op     = (state_q == S_EXEC) && (op inside {LD, ST, ADD, IN, OUT});
  assign bound_state = (ie_q && intr_i) ? S_INTA : S_FETCH;  // sampled per instruction
  assign jmp_taken   = !ir_q.mem.byte_op || zf_q;

  // bus request level
  assign mem_op_o = (state_q inside {S_FETCH, S_IMM, S_INTA}) || data_op;
  assign inta_o   = (state_q == S_INTA);

  always_comb begin
    req_o         = '0;
    req_o.dat     = acc_q;
    req_o.m_io    = 1'b1;  // fetches are memory reads
    if (state_q == S_EXEC) begin
      req_o.byte_op = ir_q.mem.byte_op;
      req_o.we      = op inside {ST, OUT};
      req_o.m_io    = !io_op;
      if (io_op) req_o.adr = {12'h000, ir_q.io.port};  // port is the address
    end else if (state_q == S_INTA) begin
      req_o.byte_op = 1'b1;  // vector sits on the low lane of port 0
      req_o.m_io    = 1'b0;
      req_o.inta    = 1'b1;
    end
  end

  // segment block steering, fetches always through CS
  assign seg_sel_o = (state_q == S_EXEC) ? ir_q.mem.seg : CS;
  assign offset_o  = (state_q == S_EXEC) ? {7'h00, ir_q.mem.offset} : ip_q;
  assign seg_we_o  = (state_q == S_EXEC) && (op == SEGLD);
  assign seg_dat_o = acc_q;

  assign pc_o = {cs_q, 4'h0} + {4'h0, ip_q};

  // accumulator source
  assign result   = (op == ADD) ? acc_q + dat_i : dat_i;
  assign load_acc = !block_i &&
                    (((state_q == S_IMM) && (op == LDI)) ||
                     ((state_q == S_EXEC) && (op inside {LD, ADD, IN})));

  // sequencer and control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_FETCH;
      ip_q    <= `MCPU_RESET_IP;
      cs_q    <= `MCPU_RESET_CS;
      ie_q    <= 1'b0;
    end else begin
      unique case (state_q)
        S_FETCH: begin
          if (!block_i) begin
            ip_q    <= ip_q + 16'd2;
            state_q <= (fetched.mem.op inside {LDI, JMP}) ? S_IMM : S_EXEC;
          end
        end
        S_IMM: begin
          if (!block_i) begin
            ip_q    <= (op == JMP && jmp_taken) ? dat_i : ip_q + 16'd2;
            state_q <= bound_state;
          end
        end
        S_EXEC: begin
          if (!block_i) begin  // low at once when no bus cycle
            state_q <= bound_state;
            case (op)
              EI:      ie_q <= 1'b1;
              DI:      ie_q <= 1'b0;
              IRET: begin
                ip_q <= saved_ip_q;
                ie_q <= 1'b1;
              end
              SEGLD:   if (ir_q.mem.seg == CS) cs_q <= acc_q;
              HLT:     state_q <= S_HALT;  // no way out but reset
              default: ;
            endcase
          end
        end
        S_INTA: begin
          if (!block_i) begin
            ip_q    <= {8'h00, iid_dat_i[7:0]} << `MCPU_VEC_SHIFT;
            ie_q    <= 1'b0;  // no nesting
            state_q <= S_FETCH;
          end
        end
        default: ;  // halted
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    if (state_q == S_FETCH && !block_i) ir_q <= fetched;
    if (state_q == S_INTA && !block_i) saved_ip_q <= ip_q;  // return point
    if (load_acc) begin
      acc_q <= result;
      zf_q  <= (result == 16'h0000);
    end
  end

endmodule

// ==== hw/mcpu_segment_regs.sv ====
`timescale 1ns/100ps

`include "mcpu_config.svh"

module mcpu_segment_regs (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   we_i,      // SEGLD strobe
  input  mcpu_isa_pkg::seg_sel_e sel_i,     // write target and read source
  input  logic [15:0]            dat_i,
  input  logic [15:0]            offset_i,
  output logic [19:0]            adr_o      // seg * 16 + offset
);

  import mcpu_isa_pkg::*;

  logic [15:0] seg_q [4];  // indexed by seg_sel_e
  logic [19:0] base;

  // CS points at boot code, the rest start at the bottom of memory
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seg_q[CS] <= `MCPU_RESET_CS;
      seg_q[DS] <= 16'h0000;
      seg_q[SS] <= 16'h0000;
      seg_q[ES] <= 16'h0000;
    end else if (we_i) begin
      seg_q[sel_i] <= dat_i;
    end
  end

  // paragraph base of the selected segment
  assign base = {seg_q[sel_i], 4'h0};

  // 20 bit adder, carry out dropped so it wraps like real mode
  assign adr_o = base + {4'h0, offset_i};

endmodule

// ==== hw/mcpu_isa_pkg.sv ====
package mcpu_isa_pkg;

  // 4 bit opcode in the top nibble of every instruction word
  typedef enum logic [3:0] {
    NOP   = 4'h0,
    LDI   = 4'h1,  // acc <= next word
    LD    = 4'h2,  // acc <= mem[seg:offset]
    ST    = 4'h3,  // mem[seg:offset] <= acc
    ADD   = 4'h4,  // acc <= acc + mem[seg:offset]
    IN    = 4'h5,  // acc <= io[port]
    OUT   = 4'h6,  // io[port] <= acc
    SEGLD = 4'h7,  // seg <= acc
    JMP   = 4'h8,  // ip <= next word, only when zf if byte flag set
    EI    = 4'h9,
    DI    = 4'ha,
    IRET  = 4'hb,  // ip <= saved ip, interrupts back on
    HLT   = 4'hc
  } opcode_e;

  // segment register index
  typedef enum logic [1:0] {
    CS = 2'd0,
    DS = 2'd1,
    SS = 2'd2,
    ES = 2'd3
  } seg_sel_e;

  // memory operand form
  typedef struct packed {
    opcode_e     op;
    logic        byte_op;
    seg_sel_e    seg;
    logic [ 8:0] offset;  // zero extended to 16 bits
  } instr_mem_t;

  // io operand form
  typedef struct packed {
    opcode_e     op;
    logic        byte_op;
    logic [ 2:0] unused;
    logic [ 7:0] port;
  } instr_io_t;

  // same word, decoded by opcode class
  typedef union packed {
    instr_mem_t mem;
    instr_io_t  io;
  } instr_u;

endpackage

// ==== hw/mcpu_bus_pkg.sv ====
package mcpu_bus_pkg;

  // request from core to bus master
  // held stable for as long as mem_op is high
  typedef struct packed {
    logic [19:0] adr;     // physical byte address, or port number for io
    logic [15:0] dat;     // write data, low byte used on byte writes
    logic        byte_op; // byte access
    logic        we;      // write
    logic        m_io;    // 1 memory, 0 io
    logic        inta;    // interrupt acknowledge cycle
  } cpu_req_t;

  // wishbone master side, all registered in the master
  typedef struct packed {
    logic [15:0] dat;     // write data, byte ops replicated on both lanes
    logic [19:1] adr;     // word address
    logic        we;
    logic        tga;     // copy of m_io
    logic [ 1:0] sel;     // byte lane enables
    logic        stb;
    logic        cyc;
  } wb_out_t;

endpackage

// ==== include/mcpu_config.svh ====
`ifndef MCPU_CONFIG_SVH
`define MCPU_CONFIG_SVH

// code segment loaded into CS by reset
`define MCPU_RESET_CS 16'h0000

// first instruction offset inside CS
`define MCPU_RESET_IP 16'h0100

// handler offset = vector byte << shift, i.e. four bytes per vector
`define MCPU_VEC_SHIFT 2

`endif
